/* src/rv_isa_pkg.sv */
// ISA side definitions for the small RV32I core
// instruction subset, core FSM states and the decoded instruction word
// referenced by scoped names from rv_core

package rv_isa_pkg;

    // supported instruction kinds
    typedef enum logic [3:0] {
        op_addi    = 4'd0,
        op_add     = 4'd1,
        op_sub     = 4'd2,
        op_lui     = 4'd3,
        op_beq     = 4'd4,
        op_bne     = 4'd5,
        op_sw      = 4'd6,
        op_ebreak  = 4'd7,
        op_illegal = 4'd8  // anything outside the subset
    } rv_op_e;

    // multicycle core FSM
    typedef enum logic [1:0] {
        st_fetch = 2'd0, // issue fetch once the credit is held
        st_wait  = 2'd1, // wait for the fetch response
        st_exec  = 2'd2, // execute in one cycle
        st_halt  = 2'd3  // parked after ebreak or illegal word
    } core_state_e;

    // decoded instruction, 52 bits
    typedef struct packed {
        rv_op_e      op;
        logic        reg_we; // result goes to rd
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;    // already sign extended
    } decoded_t;

endpackage

/* src/rv_mem_pkg.sv */
// memory side definitions shared by the fetch path and the counter
// line geometry, core/cache and cache/ROM link structs,
// and the memory-mapped counter registers

package rv_mem_pkg;

    localparam int LINE_WORDS = 4; // words per cache line

    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    // core -> cache
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    // cache -> core
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } fetch_rsp_t;

    // cache -> ROM controller, pc[31:4]
    typedef struct packed {
        logic        valid;
        logic [27:0] line_addr;
    } fill_req_t;

    // ROM controller -> cache
    typedef struct packed {
        logic  valid;
        line_t line;
    } fill_rsp_t;

    // counter control, MMIO window at ffff0000
    localparam logic [31:0] MMIO_CNT_EN_ADDR  = 32'hffff_0020;
    localparam logic [31:0] MMIO_CNT_CLR_ADDR = 32'hffff_0120;

    // core -> counter, one pulse per executed sw
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } mmio_wr_t;

endpackage

/* src/rv_core.sv */
// multicycle RV32I subset core
// fetch, wait and execute states; one fetch credit towards the cache
// sw only reaches the memory-mapped registers, ebreak halts the core
// dbg port reads the register file combinationally

`timescale 1ns/10ps

module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    output rv_mem_pkg::fetch_req_t fetch_req_o,
    input  rv_mem_pkg::fetch_rsp_t fetch_rsp_i,
    output rv_mem_pkg::mmio_wr_t   mmio_wr_o,
    input  logic [4:0]             dbg_addr_i,
    output logic [31:0]            dbg_data_o,
    output logic                   halt_o
);

    rv_isa_pkg::core_state_e state_q;
    rv_isa_pkg::decoded_t    dec;

    logic [31:0] pc_q;
    logic [31:0] instr_q;         // word under execution
    logic        credit_q;        // fetch credit
    logic [31:0] regs [32];       // x0 slot never written
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic [31:0] alu_res;
    logic        br_taken;
    logic        issue;

    // ------------------------------
    // decode
    // ------------------------------
    function automatic rv_isa_pkg::decoded_t decode(input logic [31:0] w);
        rv_isa_pkg::decoded_t d;
        d        = '0;
        d.op     = rv_isa_pkg::op_illegal;
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        case (w[6:0])
            7'b0010011: begin // op-imm group with addi only
                if (w[14:12] == 3'b000) begin
                    d.op     = rv_isa_pkg::op_addi;
                    d.reg_we = 1'b1;
                end
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            7'b0110011: begin // register ops add and sub only
                d.reg_we = (w[14:12] == 3'b000);
                if (w[14:12] == 3'b000 && w[31:25] == 7'b0000000)
                    d.op = rv_isa_pkg::op_add;
                else if (w[14:12] == 3'b000 && w[31:25] == 7'b0100000)
                    d.op = rv_isa_pkg::op_sub;
                else
                    d.reg_we = 1'b0;
            end
            7'b0110111: begin // lui
                d.op     = rv_isa_pkg::op_lui;
                d.reg_we = 1'b1;
                d.imm    = {w[31:12], 12'b0};
            end
            7'b1100011: begin // beq and bne with B-type imm
                if (w[14:12] == 3'b000)
                    d.op = rv_isa_pkg::op_beq;
                else if (w[14:12] == 3'b001)
                    d.op = rv_isa_pkg::op_bne;
                d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b0100011: begin // word stores only
                if (w[14:12] == 3'b010)
                    d.op = rv_isa_pkg::op_sw;
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            7'b1110011: begin // system
                if (w == 32'h0010_0073)
                    d.op = rv_isa_pkg::op_ebreak;
            end
            default: d.op = rv_isa_pkg::op_illegal;
        endcase
        return d;
    endfunction

    assign dec   = decode(instr_q);
    assign rs1_v = (dec.rs1 == 5'd0) ? 32'd0 : regs[dec.rs1];
    assign rs2_v = (dec.rs2 == 5'd0) ? 32'd0 : regs[dec.rs2];

    // ------------------------------
    // execute
    // ------------------------------
    always_comb begin
        case (dec.op)
            rv_isa_pkg::op_addi: alu_res = rs1_v + dec.imm;
            rv_isa_pkg::op_add:  alu_res = rs1_v + rs2_v;
            rv_isa_pkg::op_sub:  alu_res = rs1_v - rs2_v;
            rv_isa_pkg::op_lui:  alu_res = dec.imm;
            default:             alu_res = 32'd0;
        endcase
    end

    assign br_taken = (dec.op == rv_isa_pkg::op_beq && rs1_v == rs2_v) ||
                      (dec.op == rv_isa_pkg::op_bne && rs1_v != rs2_v);

    // register file write
    always_ff @(posedge clk) begin
        if (state_q == rv_isa_pkg::st_exec && dec.reg_we && dec.rd != 5'd0)
            regs[dec.rd] <= alu_res;
    end

    always_ff @(posedge clk) begin
        if (fetch_rsp_i.valid)
            instr_q <= fetch_rsp_i.instr; // latch fetched word
    end

    // ------------------------------
    // control FSM and fetch credit
    // ------------------------------
    assign issue = !rst && (state_q == rv_isa_pkg::st_fetch) && credit_q; // quiet in reset

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= rv_isa_pkg::st_fetch;
            pc_q     <= 32'd0;
            credit_q <= 1'b1; // one buffer in the cache
        end else begin
            credit_q <= (credit_q & ~issue) | fetch_rsp_i.valid;
            case (state_q)
                rv_isa_pkg::st_fetch:
                    if (issue) state_q <= rv_isa_pkg::st_wait;
                rv_isa_pkg::st_wait:
                    if (fetch_rsp_i.valid) state_q <= rv_isa_pkg::st_exec;
                rv_isa_pkg::st_exec: begin
                    if (dec.op == rv_isa_pkg::op_ebreak || dec.op == rv_isa_pkg::op_illegal) begin
                        state_q <= rv_isa_pkg::st_halt;
                    end else begin
                        state_q <= rv_isa_pkg::st_fetch;
                        pc_q    <= br_taken ? pc_q + dec.imm : pc_q + 32'd4;
                    end
                end
                default: state_q <= rv_isa_pkg::st_halt; // stays parked
            endcase
        end
    end

    assign fetch_req_o = '{valid: issue, pc: pc_q};

    // store goes out during the execute cycle
    assign mmio_wr_o = '{valid: (state_q == rv_isa_pkg::st_exec) &&
                                (dec.op == rv_isa_pkg::op_sw),
                         addr:  rs1_v + dec.imm,
                         data:  rs2_v};

    assign dbg_data_o = (dbg_addr_i == 5'd0) ? 32'd0 : regs[dbg_addr_i];
    assign halt_o     = (state_q == rv_isa_pkg::st_halt);

endmodule

/* src/rv_icache.sv */
// direct-mapped instruction cache between core and ROM controller
// hit answers in the cycle after the request, a miss spends the fill
// credit and answers one cycle after the line comes back
// CACHE_EN = 0 forces every access to miss

`timescale 1ns/10ps

module rv_icache #(
    parameter bit CACHE_EN    = 1'b1,
    parameter int CACHE_LINES = 8     // power of two
) (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_mem_pkg::fetch_req_t fetch_req_i,
    output rv_mem_pkg::fetch_rsp_t fetch_rsp_o,
    output rv_mem_pkg::fill_req_t  fill_req_o,
    input  rv_mem_pkg::fill_rsp_t  fill_rsp_i
);

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = 28 - IDX_W; // pc[31:4] minus index

    typedef enum logic [1:0] {
        c_idle, // accept lookups
        c_miss, // waiting for a fill credit
        c_fill  // line request outstanding
    } cache_state_e;

    cache_state_e      state_q;
    rv_mem_pkg::line_t data_q  [CACHE_LINES];
    logic [TAG_W-1:0]  tag_q   [CACHE_LINES];
    logic              valid_q [CACHE_LINES];

    logic [31:0]      pc_q;         // pc of the access in flight
    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [IDX_W-1:0] miss_idx;
    logic             hit;
    logic             fill_issue;
    logic [1:0]       fill_credit_q;
    logic             rsp_valid_q;
    logic [31:0]      rsp_instr_q;

    assign req_idx  = fetch_req_i.pc[4 +: IDX_W];
    assign req_tag  = fetch_req_i.pc[31 -: TAG_W];
    assign miss_idx = pc_q[4 +: IDX_W];
    assign hit      = CACHE_EN && valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    assign fill_issue = (state_q == c_miss) && (fill_credit_q != 2'd0);
    assign fill_req_o = '{valid: fill_issue, line_addr: pc_q[31:4]};

    // ------------------------------
    // miss FSM and fill credit
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= c_idle;
            fill_credit_q <= 2'd1;
            rsp_valid_q   <= 1'b0;
            for (int i = 0; i < CACHE_LINES; i++)
                valid_q[i] <= 1'b0;
        end else begin
            fill_credit_q <= fill_credit_q - {1'b0, fill_issue} + {1'b0, fill_rsp_i.valid};
            rsp_valid_q   <= 1'b0;
            case (state_q)
                c_idle:
                    if (fetch_req_i.valid) begin
                        if (hit) rsp_valid_q <= 1'b1;
                        else     state_q     <= c_miss;
                    end
                c_miss:
                    if (fill_issue) state_q <= c_fill;
                default:
                    if (fill_rsp_i.valid) begin
                        valid_q[miss_idx] <= 1'b1;
                        rsp_valid_q       <= 1'b1;
                        state_q           <= c_idle;
                    end
            endcase
        end
    end

    // arrays and payload
    always_ff @(posedge clk) begin
        if (state_q == c_idle && fetch_req_i.valid) begin
            pc_q        <= fetch_req_i.pc;
            rsp_instr_q <= data_q[req_idx][fetch_req_i.pc[3:2]];
        end
        if (state_q == c_fill && fill_rsp_i.valid) begin
            data_q[miss_idx] <= fill_rsp_i.line;
            tag_q[miss_idx]  <= pc_q[31 -: TAG_W];
            rsp_instr_q      <= fill_rsp_i.line[pc_q[3:2]]; // word from the new line
        end
    end

    assign fetch_rsp_o = '{valid: rsp_valid_q, instr: rsp_instr_q};

    // ------------------------------
    // credit checks
    // ------------------------------
    a_fill_credit_range: assert property (@(posedge clk) disable iff (rst)
        fill_credit_q <= 2'd1)
        else $error("fill credit out of range");

    a_fill_rsp_outstanding: assert property (@(posedge clk) disable iff (rst)
        fill_rsp_i.valid |-> fill_credit_q == 2'd0)
        else $error("fill response without outstanding request");

endmodule

/* src/rv_rom_ctrl.sv */
// line-fill controller in front of the external instruction ROM
// reads the four words of a line one per cycle from the line base
// and returns the collected line one cycle after the last word

`timescale 1ns/10ps

module rv_rom_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_mem_pkg::fill_req_t fill_req_i,
    output rv_mem_pkg::fill_rsp_t fill_rsp_o,
    output logic [31:0]           rom_addr_o,
    output logic                  rom_req_o,
    input  logic [31:0]           rom_data_i
);

    localparam int CNT_W = $clog2(rv_mem_pkg::LINE_WORDS);

    typedef enum logic {
        r_idle, // waiting for a fill request
        r_read  // stepping through the line
    } rom_state_e;

    rom_state_e        state_q;
    logic [CNT_W-1:0]  word_q;     // word within the line
    logic [27:0]       base_q;     // line address
    rv_mem_pkg::line_t line_q;     // collected words
    logic              rsp_valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= r_idle;
            word_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                r_idle:
                    if (fill_req_i.valid) begin
                        state_q <= r_read;
                        word_q  <= '0;
                    end
                default: begin
                    word_q <= word_q + 1'b1;
                    if (word_q == CNT_W'(rv_mem_pkg::LINE_WORDS - 1)) begin
                        state_q     <= r_idle;
                        rsp_valid_q <= 1'b1; // all words in
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == r_idle && fill_req_i.valid)
            base_q <= fill_req_i.line_addr;
        if (state_q == r_read)
            line_q[word_q] <= rom_data_i; // ROM answers in the same cycle
    end

    assign rom_req_o  = (state_q == r_read);
    assign rom_addr_o = {base_q, word_q, 2'b00};
    assign fill_rsp_o = '{valid: rsp_valid_q, line: line_q};

    // the cache holds one credit, so requests never overlap a fill
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        fill_req_i.valid |-> state_q == r_idle && !rsp_valid_q)
        else $error("fill request during a fill");

endmodule

/* src/rv_cycle_counter.sv */
// performance cycle counter behind two memory-mapped registers
// bit 0 of a store to the enable address starts or stops counting,
// bit 0 of a store to the clear address holds the count at zero

`timescale 1ns/10ps

module rv_cycle_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_mem_pkg::mmio_wr_t mmio_wr_i,
    output logic [31:0]          cycle_cnt_o
);

    logic        en_q;
    logic        clr_q;
    logic [31:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            en_q  <= 1'b0;
            clr_q <= 1'b0;
            cnt_q <= 32'd0;
        end else begin
            if (mmio_wr_i.valid && mmio_wr_i.addr == rv_mem_pkg::MMIO_CNT_EN_ADDR)
                en_q <= mmio_wr_i.data[0];
            if (mmio_wr_i.valid && mmio_wr_i.addr == rv_mem_pkg::MMIO_CNT_CLR_ADDR)
                clr_q <= mmio_wr_i.data[0];
            if (clr_q)
                cnt_q <= 32'd0;
            else if (en_q)
                cnt_q <= cnt_q + 32'd1;
        end
    end

    assign cycle_cnt_o = clr_q ? 32'd0 : cnt_q; // zero while clear is set

endmodule

/* src/rv_soc.sv */
// top level of the fetch-path SoC
// core fetches through the instruction cache, the cache fills lines
// from the external ROM through the line-fill controller
// core stores drive the cycle counter registers

`timescale 1ns/10ps

module rv_soc #(
    parameter bit CACHE_EN    = 1'b1,
    parameter int CACHE_LINES = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] rom_data_i,
    output logic [31:0] rom_addr_o,
    output logic        rom_req_o,
    input  logic [4:0]  dbg_addr_i,
    output logic [31:0] dbg_data_o,
    output logic        halt_o,
    output logic [31:0] cycle_cnt_o
);

    rv_mem_pkg::fetch_req_t fetch_req; // core -> cache
    rv_mem_pkg::fetch_rsp_t fetch_rsp;
    rv_mem_pkg::fill_req_t  fill_req;  // cache -> ROM controller
    rv_mem_pkg::fill_rsp_t  fill_rsp;
    rv_mem_pkg::mmio_wr_t   mmio_wr;   // core -> counter

    rv_core u_core (
        .clk         (clk),
        .rst         (rst),
        .fetch_req_o (fetch_req),
        .fetch_rsp_i (fetch_rsp),
        .mmio_wr_o   (mmio_wr),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_data_o  (dbg_data_o),
        .halt_o      (halt_o)
    );

    rv_icache #(
        .CACHE_EN    (CACHE_EN),
        .CACHE_LINES (CACHE_LINES)
    ) u_icache (
        .clk         (clk),
        .rst         (rst),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .fill_req_o  (fill_req),
        .fill_rsp_i  (fill_rsp)
    );

    rv_rom_ctrl u_rom_ctrl (
        .clk         (clk),
        .rst         (rst),
        .fill_req_i  (fill_req),
        .fill_rsp_o  (fill_rsp),
        .rom_addr_o  (rom_addr_o),
        .rom_req_o   (rom_req_o),
        .rom_data_i  (rom_data_i)
    );

    rv_cycle_counter u_cycle_counter (
        .clk         (clk),
        .rst         (rst),
        .mmio_wr_i   (mmio_wr),
        .cycle_cnt_o (cycle_cnt_o)
    );

endmodule

/* test/tb_rv_soc.sv */
// testbench for the fetch-path SoC
// loads the program image and expected registers from the trace file,
// models the instruction ROM, runs until ebreak halts the core, then
// checks registers, ROM bursts and the frozen cycle counter

`timescale 1ns/10ps

module tb_rv_soc;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;  // after the rising edge
    localparam int RESET_CYCLES = 16;
    localparam int TRACE_DEPTH  = 256;
    localparam int ROM_DEPTH    = 64;  // words
    localparam int HDR_WORDS    = 3;   // rom words, lines, reg checks
    localparam int LINE_WORDS   = 4;
    localparam int HOLD_CYCLES  = 20;  // counter must stay frozen

    logic        clk;
    logic        rst;
    logic [31:0] rom_data;
    logic [31:0] rom_addr;
    logic        rom_req;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;
    logic        halt;
    logic [31:0] cycle_cnt;

    logic [31:0] trace_mem [TRACE_DEPTH];
    logic [31:0] rom_mem   [ROM_DEPTH];
    int          n_rom          = 0;
    int          n_lines        = 0;
    int          n_regs         = 0;
    int          timeout_cycles = 0;
    int          burst_count    = 0;
    int          beat_count     = 0;
    logic [31:0] next_addr      = '0;
    logic        req_prev       = 1'b0;

    rv_soc #(
        .CACHE_EN    (1'b1),
        .CACHE_LINES (8)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .rom_data_i  (rom_data),
        .rom_addr_o  (rom_addr),
        .rom_req_o   (rom_req),
        .dbg_addr_i  (dbg_addr),
        .dbg_data_o  (dbg_data),
        .halt_o      (halt),
        .cycle_cnt_o (cycle_cnt)
    );

    // ROM model returns an address pattern past the image
    assign rom_data = (rom_addr[31:2] < n_rom) ? rom_mem[rom_addr[31:2]]
                                               : (32'hbad0_0000 ^ rom_addr);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic read_register(input logic [4:0] idx, output logic [31:0] value);
        @(posedge clk);
        #(DRIVE_DELAY);
        dbg_addr = idx;
        @(negedge clk); // dbg port is combinational
        value = dbg_data;
    endtask

    // ------------------------------
    // ROM burst monitor
    // ------------------------------
    always @(negedge clk) begin
        if (rst) begin
            req_prev = 1'b0;
        end else begin
            if (rom_req && !req_prev) begin // rising edge starts a new burst
                burst_count++;
                assert (rom_addr[3:0] == 4'h0) else abort_run($sformatf(
                    "Error: rom_addr_o burst base got %h expected line aligned", rom_addr));
                next_addr  = rom_addr + 32'd4;
                beat_count = 1;
            end else if (rom_req) begin
                assert (rom_addr == next_addr) else abort_run($sformatf(
                    "Error: rom_addr_o got %h expected %h", rom_addr, next_addr));
                next_addr  = next_addr + 32'd4;
                beat_count++;
            end else if (req_prev) begin
                assert (beat_count == LINE_WORDS) else abort_run($sformatf(
                    "Error: rom_req_o burst length got %h expected %h",
                    beat_count, LINE_WORDS));
            end
            req_prev = rom_req;
        end
    end

    // timeout counted from reset release
    initial begin
        int cycles;
        cycles = 0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        forever begin
            @(negedge clk);
            cycles++;
            assert (halt === 1'b1 || cycles <= timeout_cycles) else abort_run($sformatf(
                "timeout: the core did not halt within %0d cycles", timeout_cycles));
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        logic [31:0] got;
        logic [31:0] frozen;
        int          base;
        rst      = 1'b1;
        dbg_addr = 5'd0;
        $readmemh("test/rv_soc_trace.txt", trace_mem);
        assert (!$isunknown(trace_mem[0]) && !$isunknown(trace_mem[2]))
            else abort_run("the trace file could not be read");
        n_rom   = trace_mem[0];
        n_lines = trace_mem[1];
        n_regs  = trace_mem[2];
        assert (n_rom > 0 && n_rom <= ROM_DEPTH)
            else abort_run("the trace file holds no usable ROM image");
        for (int i = 0; i < n_rom; i++)
            rom_mem[i] = trace_mem[HDR_WORDS + i];
        timeout_cycles = 200 * n_rom; // 200 cycles per ROM word

        // reset values sampled in the last reset cycle
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        assert (halt === 1'b0)
            else abort_run($sformatf("Error: halt_o got %h expected %h", halt, 1'b0));
        assert (rom_req === 1'b0)
            else abort_run($sformatf("Error: rom_req_o got %h expected %h", rom_req, 1'b0));
        assert (cycle_cnt === 32'd0)
            else abort_run($sformatf("Error: cycle_cnt_o got %h expected %h", cycle_cnt, 32'd0));
        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;

        while (halt !== 1'b1) @(negedge clk); // timeout guards this

        base = HDR_WORDS + n_rom;
        for (int k = 0; k < n_regs; k++) begin
            read_register(trace_mem[base + 2 * k][4:0], got);
            assert (got === trace_mem[base + 2 * k + 1]) else abort_run($sformatf(
                "Error: dbg_data_o x%0d got %h expected %h",
                trace_mem[base + 2 * k][4:0], got, trace_mem[base + 2 * k + 1]));
        end

        // each line filled once
        assert (burst_count == n_lines) else abort_run($sformatf(
            "Error: rom_req_o burst count got %h expected %h", burst_count, n_lines));

        frozen = cycle_cnt;
        assert (!$isunknown(frozen) && frozen != 32'd0) else abort_run($sformatf(
            "Error: cycle_cnt_o got %h expected non-zero", frozen));
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (cycle_cnt === frozen) else abort_run($sformatf(
                "Error: cycle_cnt_o got %h expected %h", cycle_cnt, frozen));
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* rv_soc.f */
src/rv_isa_pkg.sv
src/rv_mem_pkg.sv
src/rv_core.sv
src/rv_icache.sv
src/rv_rom_ctrl.sv
src/rv_cycle_counter.sv
src/rv_soc.sv
test/tb_rv_soc.sv

/* test/rv_soc_trace.txt */
// header: ROM word count, distinct line count, register check count
// then one ROM word per line from address 0, then register number and expected value
00000010 // 16 ROM words
00000004 // lines filled once each
00000007 // register checks
// line 0
ffff02b7 // 00 lui  x5, 0xffff0
00100313 // 04 addi x6, x0, 1
0262a023 // 08 sw   x6, 32(x5)   counter on
00300093 // 0c addi x1, x0, 3    loop count
// line 1
00000113 // 10 addi x2, x0, 0
00a00193 // 14 addi x3, x0, 10
00510113 // 18 loop: addi x2, x2, 5
00310233 // 1c add  x4, x2, x3
// line 2
406201b3 // 20 sub  x3, x4, x6
fff08093 // 24 addi x1, x1, -1
fe0098e3 // 28 bne  x1, x0, loop
00000463 // 2c beq  x0, x0, +8
// line 3
06300313 // 30 addi x6, x0, 99   skipped by beq
0202a023 // 34 sw   x0, 32(x5)   counter off
00100073 // 38 ebreak
00000000 // 3c unused
// expected registers after halt
00 00000000
01 00000000
02 0000000f
03 00000025
04 00000026
05 ffff0000
06 00000001
